// File: verif/cpci_stim.txt
// Columns op_addr_wrdata_expected, op 1 is a read and 0 is a write
// Address is 7 hex digits, write data and expected read data 8 hex digits each
1_0000000_00000000_00000000
1_000000f_00000000_00000000
1_0000011_00000000_00000000
0_0000003_a5a50003_00000000
0_0000007_12345678_00000000
1_0000003_00000000_a5a50003
1_0000007_00000000_12345678
1_0000005_00000000_00000000
1_0000010_00000000_43504349
0_0000010_ffffffff_00000000
1_0000010_00000000_43504349
1_0000012_00000000_deadbeef
1_7ffffff_00000000_deadbeef
0_0000008_c0de0008_00000000
0_0000009_c0de0009_00000000
0_000000a_c0de000a_00000000
0_000000b_c0de000b_00000000
0_000000c_c0de000c_00000000
0_000000d_c0de000d_00000000
0_000000e_c0de000e_00000000
0_000000f_c0de000f_00000000
1_0000011_00000000_0000000b
1_000000f_00000000_c0de000f
1_0000008_00000000_c0de0008
1_0000003_00000000_a5a50003

// File: cpci_subsys.f
src/cpci_bus_pkg.sv
src/sync_fifo.sv
src/reg_block.sv
src/cpci_bus_ctrl.sv
src/cpci_subsys.sv
verif/cpci_checker.sv
verif/cpci_subsys_assert.sv
verif/tb_cpci_subsys.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the CPCI subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f cpci_subsys.f --top-module tb_cpci_subsys -o sim_tb
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

# Keep running past assertion errors so the testbench prints its verdict
out=$(./obj_dir/sim_tb +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -q "Result: PASSED"; then
   exit 0
fi
exit 1

// File: verif/tb_cpci_subsys.sv
// CPCI subsystem testbench
`timescale 1ns/1ps

module tb_cpci_subsys import cpci_bus_pkg::*; ();

   localparam int RESET_CYCLES = 5;
   localparam int MAX_OPS      = 64;
   // Cycle budget per stim line
   localparam int OP_CYCLES    = 40;
   // Longest wait for a reply or for write-ready
   localparam int READ_LIMIT   = 20;
   // Stim word holds op, address, write data and expected data
   // Op nibble 1 marks a read and 0 a write
   localparam logic [3:0] END_OP = 4'hf;

   logic  pci_clk;
   logic  reset_pci;
   logic  cpci_req;
   logic  cpci_rd_wr_l;
   addr_t cpci_addr;
   data_t cpci_wr_data;
   logic  cpci_wr_rdy;
   logic  cpci_rd_rdy;
   logic  cpci_data_tri_en;
   data_t cpci_rd_data;

   // Expected reply handed to the checker
   logic  exp_push;
   data_t exp_data;
   addr_t exp_addr;
   int    mismatch_count;
   int    error_count;
   int    read_count;

   logic [95:0] stim [MAX_OPS];
   int          num_ops;
   int          cycle_count = 0;
   int          cycle_limit;
   int          drive_errors;
   int          total_errors;

   cpci_subsys dut (
      .pci_clk          (pci_clk),
      .reset_pci        (reset_pci),
      .cpci_req         (cpci_req),
      .cpci_rd_wr_l     (cpci_rd_wr_l),
      .cpci_addr        (cpci_addr),
      .cpci_wr_data     (cpci_wr_data),
      .cpci_wr_rdy      (cpci_wr_rdy),
      .cpci_rd_rdy      (cpci_rd_rdy),
      .cpci_data_tri_en (cpci_data_tri_en),
      .cpci_rd_data     (cpci_rd_data)
   );

   cpci_checker #(
      .READ_LIMIT (READ_LIMIT)
   ) u_checker (
      .pci_clk        (pci_clk),
      .reset_pci      (reset_pci),
      .exp_push       (exp_push),
      .exp_data       (exp_data),
      .exp_addr       (exp_addr),
      .cpci_wr_rdy    (cpci_wr_rdy),
      .cpci_rd_rdy    (cpci_rd_rdy),
      .cpci_rd_data   (cpci_rd_data),
      .mismatch_count (mismatch_count),
      .error_count    (error_count),
      .read_count     (read_count)
   );

   // --------------------
   // Clock and timeout
   // --------------------

   // 4 ns period
   always begin
      pci_clk = 1'b0;
      #2;
      pci_clk = 1'b1;
      #2;
   end

   always @(posedge pci_clk) begin
      cycle_count++;
      if (cycle_count >= cycle_limit) begin
         $display("Error: run stopped by timeout after %0d cycles", cycle_count);
         $display("Result: FAILED");
         $finish;
      end
   end

   // --------------------
   // Host driver
   // --------------------

   // One-cycle request strobe once write-ready is up
   task automatic write_reg(input addr_t addr, input data_t data);
      int waited;
      waited = 0;
      while (!cpci_wr_rdy && waited < READ_LIMIT) begin
         @(posedge pci_clk);
         #1;
         waited++;
      end
      if (!cpci_wr_rdy) begin
         $display("Error: cpci_wr_rdy stayed low, write to %h was not issued", addr);
         drive_errors++;
      end else begin
         cpci_req     = 1'b1;
         cpci_rd_wr_l = 1'b0;
         cpci_addr    = addr;
         cpci_wr_data = data;
         @(posedge pci_clk);
         #1;
         // Low for a cycle before the next request
         cpci_req = 1'b0;
         @(posedge pci_clk);
         #1;
      end
   endtask

   // Request held until the reply strobe is seen
   task automatic read_reg(input addr_t addr, input data_t expected);
      int waited;
      waited = 0;
      cpci_req     = 1'b1;
      cpci_rd_wr_l = 1'b1;
      cpci_addr    = addr;
      exp_push     = 1'b1;
      exp_data     = expected;
      exp_addr     = addr;
      @(posedge pci_clk);
      #1;
      exp_push = 1'b0;
      while (!cpci_rd_rdy && waited < READ_LIMIT) begin
         @(posedge pci_clk);
         #1;
         waited++;
      end
      // Release the request once the reply is in or the wait runs out
      cpci_req = 1'b0;
      @(posedge pci_clk);
      #1;
   endtask

   initial begin
      cpci_req     = 1'b0;
      cpci_rd_wr_l = 1'b0;
      cpci_addr    = '0;
      cpci_wr_data = '0;
      exp_push     = 1'b0;
      exp_data     = '0;
      exp_addr     = '0;
      reset_pci    = 1'b1;
      drive_errors = 0;

      // Unloaded entries carry the end op and their own index
      for (int i = 0; i < MAX_OPS; i++) begin
         stim[i] = {END_OP, 92'(i)};
      end
      $readmemh("verif/cpci_stim.txt", stim);
      num_ops = 0;
      while (num_ops < MAX_OPS && stim[num_ops][95:92] <= 4'h1) begin
         num_ops++;
      end
      if (num_ops == 0) begin
         $display("Error: no operations were loaded from the stim file");
         drive_errors++;
      end
      // One spare slot for reset and the final drain
      cycle_limit = RESET_CYCLES + OP_CYCLES * (num_ops + 1);

      repeat (RESET_CYCLES) @(posedge pci_clk);
      #1;
      reset_pci = 1'b0;

      for (int n = 0; n < num_ops; n++) begin
         if (stim[n][95:92] == 4'h1) begin
            read_reg(stim[n][90:64], stim[n][31:0]);
         end else begin
            write_reg(stim[n][90:64], stim[n][63:32]);
         end
      end

      repeat (4) @(posedge pci_clk);
      #1;
      // Checker, driver and assertion failures together
      total_errors = mismatch_count + error_count + drive_errors
                   + dut.u_ctrl.u_assert.fail_count;
      $display("Reads checked %0d, mismatches %0d, other errors %0d, assertion failures %0d",
               read_count, mismatch_count, error_count + drive_errors,
               dut.u_ctrl.u_assert.fail_count);
      if (total_errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

// File: verif/cpci_subsys_assert.sv
// CPCI bus control assertions
`timescale 1ns/1ps

module cpci_subsys_assert import cpci_bus_pkg::*; (
   input logic       pci_clk,
   input logic       reset_pci,
   input logic       cpci_wr_rdy,
   input logic       cpci_rd_rdy,
   input logic       cpci_data_tri_en,
   input logic       req_push,
   input logic       req_full,
   input p2n_state_t p2n_state
);

   // Failure tally, read by the testbench top at the end
   int fail_count = 0;

   // Data pins driven exactly while the reply strobe is up
   tri_en_matches_rd_rdy: assert property (
      @(posedge pci_clk) disable iff (reset_pci)
      cpci_data_tri_en == cpci_rd_rdy
   ) else begin
      $error("cpci_data_tri_en differs from cpci_rd_rdy");
      fail_count++;
   end

   no_push_when_full: assert property (
      @(posedge pci_clk) disable iff (reset_pci)
      !(req_push && req_full)
   ) else begin
      $error("Request FIFO pushed while full");
      fail_count++;
   end

   // Reply strobe belongs to an open read
   rd_rdy_only_reading: assert property (
      @(posedge pci_clk) disable iff (reset_pci)
      $rose(cpci_rd_rdy) |-> (p2n_state == P2N_READING)
   ) else begin
      $error("cpci_rd_rdy rose outside P2N_READING");
      fail_count++;
   end

   ready_low_in_reset: assert property (
      @(posedge pci_clk)
      reset_pci |=> (!cpci_wr_rdy && !cpci_rd_rdy && !cpci_data_tri_en)
   ) else begin
      $error("Ready outputs high during reset");
      fail_count++;
   end

endmodule

bind cpci_bus_ctrl cpci_subsys_assert u_assert (
   .pci_clk          (pci_clk),
   .reset_pci        (reset_pci),
   .cpci_wr_rdy      (cpci_wr_rdy),
   .cpci_rd_rdy      (cpci_rd_rdy),
   .cpci_data_tri_en (cpci_data_tri_en),
   .req_push         (req_push),
   .req_full         (req_full),
   .p2n_state        (p2n_state)
);

// File: verif/cpci_checker.sv
// CPCI read reply checker
`timescale 1ns/1ps

module cpci_checker import cpci_bus_pkg::*; #(
   parameter int READ_LIMIT = 20
) (
   input  logic  pci_clk,
   input  logic  reset_pci,
   input  logic  exp_push,
   input  data_t exp_data,
   input  addr_t exp_addr,
   input  logic  cpci_wr_rdy,
   input  logic  cpci_rd_rdy,
   input  data_t cpci_rd_data,
   output int    mismatch_count,
   output int    error_count,
   output int    read_count
);

   // Outstanding reads in issue order
   data_t data_q [$];
   addr_t addr_q [$];
   data_t exp_word;
   addr_t exp_at;
   int    wait_cycles;
   // Edges seen since reset ended
   int    after_reset;
   logic  rdy_exp;

   initial begin
      mismatch_count = 0;
      error_count    = 0;
      read_count     = 0;
      wait_cycles    = 0;
      after_reset    = 0;
   end

   // --------------------
   // Reply compare
   // --------------------

   always @(posedge pci_clk) begin
      if (reset_pci) begin
         data_q.delete();
         addr_q.delete();
         wait_cycles = 0;
         after_reset = 0;
      end else begin
         // Write-ready still low on the first edge out of reset, up on the next
         if (after_reset < 2) begin
            after_reset++;
            rdy_exp = (after_reset == 2);
            if (cpci_wr_rdy !== rdy_exp) begin
               $display("Mismatch at %0t: cpci_wr_rdy %b after reset, expected %b",
                        $time, cpci_wr_rdy, rdy_exp);
               mismatch_count++;
            end
         end
         if (cpci_rd_rdy) begin
            // A second strobe for the same read lands here too
            if (data_q.size() == 0) begin
               $display("Error: cpci_rd_rdy pulse at %0t with no read outstanding", $time);
               error_count++;
            end else begin
               exp_word = data_q.pop_front();
               exp_at   = addr_q.pop_front();
               read_count++;
               wait_cycles = 0;
               if (cpci_rd_data !== exp_word) begin
                  $display("Mismatch at %0t: read of %h returned %h, expected %h",
                           $time, exp_at, cpci_rd_data, exp_word);
                  mismatch_count++;
               end
            end
         end else if (data_q.size() != 0) begin
            wait_cycles++;
            if (wait_cycles > READ_LIMIT) begin
               $display("Error: read of %h did not complete within %0d cycles",
                        addr_q[0], READ_LIMIT);
               error_count++;
               data_q.delete(0);
               addr_q.delete(0);
               wait_cycles = 0;
            end
         end
         // New read from the driver
         if (exp_push) begin
            data_q.push_back(exp_data);
            addr_q.push_back(exp_addr);
         end
      end
   end

endmodule

// File: src/cpci_subsys.sv
// CPCI register subsystem top
`timescale 1ns/1ps

module cpci_subsys import cpci_bus_pkg::*; (
   input  logic  pci_clk,
   input  logic  reset_pci,
   input  logic  cpci_req,
   input  logic  cpci_rd_wr_l,
   input  addr_t cpci_addr,
   input  data_t cpci_wr_data,
   output logic  cpci_wr_rdy,
   output logic  cpci_rd_rdy,
   output logic  cpci_data_tri_en,
   output data_t cpci_rd_data
);

   // --------------------
   // Interconnect
   // --------------------

   // Host to register block
   logic  req_push;
   req_t  req_din;
   logic  req_full;
   logic  req_prog_full;
   logic  req_pop;
   logic  req_empty;
   req_t  req_dout;

   // Register block back to host
   data_t bus_rd_data;
   logic  bus_rd_vld;
   logic  rsp_push;
   data_t rsp_din;
   logic  rsp_pop;
   logic  rsp_empty;
   logic  rsp_almost_full;
   data_t rsp_dout;

   cpci_bus_ctrl u_ctrl (
      .pci_clk          (pci_clk),
      .reset_pci        (reset_pci),
      .cpci_req         (cpci_req),
      .cpci_rd_wr_l     (cpci_rd_wr_l),
      .cpci_addr        (cpci_addr),
      .cpci_wr_data     (cpci_wr_data),
      .cpci_wr_rdy      (cpci_wr_rdy),
      .cpci_rd_rdy      (cpci_rd_rdy),
      .cpci_data_tri_en (cpci_data_tri_en),
      .cpci_rd_data     (cpci_rd_data),
      .req_push         (req_push),
      .req_din          (req_din),
      .req_full         (req_full),
      .req_prog_full    (req_prog_full),
      .bus_rd_data      (bus_rd_data),
      .bus_rd_vld       (bus_rd_vld),
      .rsp_push         (rsp_push),
      .rsp_din          (rsp_din),
      .rsp_pop          (rsp_pop),
      .rsp_empty        (rsp_empty),
      .rsp_almost_full  (rsp_almost_full),
      .rsp_dout         (rsp_dout)
   );

   // Requests, full entry width
   sync_fifo #(
      .WIDTH             ($bits(req_t)),
      .DEPTH             (REQ_FIFO_DEPTH),
      .ALMOST_FULL_LEVEL (REQ_FIFO_DEPTH - 1),
      .PROG_FULL_LEVEL   (REQ_PROG_FULL_LEVEL)
   ) u_req_fifo (
      .pci_clk     (pci_clk),
      .reset_pci   (reset_pci),
      .push        (req_push),
      .din         (req_din),
      .pop         (req_pop),
      .dout        (req_dout),
      .empty       (req_empty),
      .full        (req_full),
      .almost_full (),
      .prog_full   (req_prog_full)
   );

   // Read replies, data only
   sync_fifo #(
      .WIDTH             ($bits(data_t)),
      .DEPTH             (RSP_FIFO_DEPTH),
      .ALMOST_FULL_LEVEL (RSP_ALMOST_FULL_LEVEL),
      .PROG_FULL_LEVEL   (RSP_FIFO_DEPTH)
   ) u_rsp_fifo (
      .pci_clk     (pci_clk),
      .reset_pci   (reset_pci),
      .push        (rsp_push),
      .din         (rsp_din),
      .pop         (rsp_pop),
      .dout        (rsp_dout),
      .empty       (rsp_empty),
      .full        (),
      .almost_full (rsp_almost_full),
      .prog_full   ()
   );

   reg_block u_regs (
      .pci_clk     (pci_clk),
      .reset_pci   (reset_pci),
      .req_empty   (req_empty),
      .req_dout    (req_dout),
      .req_pop     (req_pop),
      .bus_rd_data (bus_rd_data),
      .bus_rd_vld  (bus_rd_vld)
   );

endmodule

// File: src/cpci_bus_ctrl.sv
// CPCI pin-side bus control
`timescale 1ns/1ps

module cpci_bus_ctrl import cpci_bus_pkg::*; (
   input  logic       pci_clk,
   input  logic       reset_pci,

   // Host pins
   input  logic       cpci_req,
   input  logic       cpci_rd_wr_l,
   input  addr_t      cpci_addr,
   input  data_t      cpci_wr_data,
   output logic       cpci_wr_rdy,
   output logic       cpci_rd_rdy,
   output logic       cpci_data_tri_en,
   output data_t      cpci_rd_data,

   // Request FIFO write side
   output logic       req_push,
   output req_t       req_din,
   input  logic       req_full,
   input  logic       req_prog_full,

   // Read replies from the register block
   input  data_t      bus_rd_data,
   input  logic       bus_rd_vld,

   // Response FIFO
   output logic       rsp_push,
   output data_t      rsp_din,
   output logic       rsp_pop,
   input  logic       rsp_empty,
   input  logic       rsp_almost_full,
   input  data_t      rsp_dout
);

   // Registered copies of the host pins
   logic       p2n_req;
   logic       p2n_rd_wr_l;
   addr_t      p2n_addr;
   data_t      p2n_wr_data;

   p2n_state_t p2n_state;
   p2n_state_t p2n_state_nxt;

   // --------------------
   // Pin input registers
   // --------------------

   // Request strobe
   always_ff @(posedge pci_clk) begin
      if (reset_pci) begin
         p2n_req <= 1'b0;
      end else begin
         p2n_req <= cpci_req;
      end
   end

   // Read/write flag, address and write data
   always_ff @(posedge pci_clk) begin
      p2n_rd_wr_l <= cpci_rd_wr_l;
      p2n_addr    <= cpci_addr;
      p2n_wr_data <= cpci_wr_data;
   end

   // --------------------
   // Request FSM
   // --------------------

   always_comb begin
      p2n_state_nxt = p2n_state;
      req_push      = 1'b0;
      case (p2n_state)
         P2N_IDLE: begin
            // Wait here while the request FIFO is full
            if (p2n_req && !req_full) begin
               req_push = 1'b1;
               // A read also waits for its reply
               if (p2n_rd_wr_l) begin
                  p2n_state_nxt = P2N_READING;
               end
            end
         end
         P2N_READING: begin
            // Reply is on the pins this cycle
            if (cpci_rd_rdy) begin
               p2n_state_nxt = P2N_RD_DONE;
            end
         end
         P2N_RD_DONE: begin
            // Host still holds the request until it has seen the reply
            if (!p2n_req) begin
               p2n_state_nxt = P2N_IDLE;
            end
         end
         default: begin
            p2n_state_nxt = P2N_IDLE;
         end
      endcase
   end

   always_ff @(posedge pci_clk) begin
      if (reset_pci) begin
         p2n_state <= P2N_IDLE;
      end else begin
         p2n_state <= p2n_state_nxt;
      end
   end

   // Same packing as the FIFO entry type
   assign req_din = {p2n_rd_wr_l, p2n_addr, p2n_wr_data};

   // --------------------
   // Read reply path
   // --------------------

   // Drop case never occurs with one read outstanding
   assign rsp_din  = bus_rd_data;
   assign rsp_push = bus_rd_vld && !rsp_almost_full;

   // Pop each reply as soon as it reaches the head
   assign rsp_pop  = !rsp_empty;

   // --------------------
   // Pin output registers
   // --------------------

   always_ff @(posedge pci_clk) begin
      if (reset_pci) begin
         cpci_wr_rdy      <= 1'b0;
         cpci_rd_rdy      <= 1'b0;
         cpci_data_tri_en <= 1'b0;
      end else begin
         // Back-pressure from the request FIFO threshold
         cpci_wr_rdy      <= !req_prog_full;
         // Drive the data pins exactly while the reply is valid
         cpci_rd_rdy      <= !rsp_empty;
         cpci_data_tri_en <= !rsp_empty;
      end
   end

   // FIFO head is valid whenever the FIFO is not empty
   always_ff @(posedge pci_clk) begin
      cpci_rd_data <= rsp_dout;
   end

endmodule

// File: src/reg_block.sv
// Register map behind the CPCI bridge
`timescale 1ns/1ps

module reg_block import cpci_bus_pkg::*; (
   input  logic  pci_clk,
   input  logic  reset_pci,

   // Request FIFO read side
   input  logic  req_empty,
   input  req_t  req_dout,
   output logic  req_pop,

   // Read reply to the control block
   output data_t bus_rd_data,
   output logic  bus_rd_vld
);

   // Fields of the head entry
   logic  req_rd;
   addr_t req_addr;
   data_t req_wdata;

   logic  is_scratch;
   data_t rd_mux;

   data_t scratch [NUM_SCRATCH];
   data_t wr_count;

   assign {req_rd, req_addr, req_wdata} = req_dout;

   // Hold off the next entry while a read reply is on its way out
   assign req_pop = !req_empty && !bus_rd_vld;

   // Word addresses 0 up to NUM_SCRATCH-1
   assign is_scratch = (req_addr < addr_t'(NUM_SCRATCH));

   // --------------------
   // Write side
   // --------------------

   always_ff @(posedge pci_clk) begin
      if (reset_pci) begin
         for (int i = 0; i < NUM_SCRATCH; i++) begin
            scratch[i] <= '0;
         end
         wr_count <= '0;
      end else if (req_pop && !req_rd) begin
         // ID, count and unmapped locations ignore write data
         if (is_scratch) begin
            scratch[req_addr[SCRATCH_IDX_W-1:0]] <= req_wdata;
         end
         // Every popped write is counted, whatever its address
         wr_count <= wr_count + 1'b1;
      end
   end

   // --------------------
   // Read side
   // --------------------

   always_comb begin
      if (is_scratch) begin
         rd_mux = scratch[req_addr[SCRATCH_IDX_W-1:0]];
      end else if (req_addr == ADDR_ID) begin
         rd_mux = ID_VALUE;
      end else if (req_addr == ADDR_WR_COUNT) begin
         rd_mux = wr_count;
      end else begin
         rd_mux = BAD_ADDR_VALUE;
      end
   end

   // Reply valid for one cycle after the pop edge
   always_ff @(posedge pci_clk) begin
      if (reset_pci) begin
         bus_rd_vld <= 1'b0;
      end else begin
         bus_rd_vld <= req_pop && req_rd;
      end
   end

   always_ff @(posedge pci_clk) begin
      if (req_pop && req_rd) begin
         bus_rd_data <= rd_mux;
      end
   end

endmodule

// File: src/sync_fifo.sv
// Single-clock FWFT FIFO
`timescale 1ns/1ps

module sync_fifo #(
   parameter int WIDTH             = 32,
   parameter int DEPTH             = 16,
   parameter int ALMOST_FULL_LEVEL = 15,
   parameter int PROG_FULL_LEVEL   = 12
) (
   input  logic             pci_clk,
   input  logic             reset_pci,
   input  logic             push,
   input  logic [WIDTH-1:0] din,
   input  logic             pop,
   output logic [WIDTH-1:0] dout,
   output logic             empty,
   output logic             full,
   output logic             almost_full,
   output logic             prog_full
);

   // Pointer indexes the storage, count needs one extra value for full
   typedef logic [$clog2(DEPTH)-1:0]   ptr_t;
   typedef logic [$clog2(DEPTH+1)-1:0] cnt_t;

   logic [WIDTH-1:0] mem [DEPTH];
   ptr_t             wr_ptr;
   ptr_t             rd_ptr;
   cnt_t             count;
   logic             wr_en;
   logic             rd_en;

   // Ignore a push when full and a pop when empty
   assign wr_en = push && !full;
   assign rd_en = pop && !empty;

   // --------------------
   // Storage
   // --------------------

   always_ff @(posedge pci_clk) begin
      if (wr_en) begin
         mem[wr_ptr] <= din;
      end
   end

   // Head word falls through to the output
   assign dout = mem[rd_ptr];

   // --------------------
   // Pointers and count
   // --------------------

   always_ff @(posedge pci_clk) begin
      if (reset_pci) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= (wr_ptr == ptr_t'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (rd_en) begin
            rd_ptr <= (rd_ptr == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         // Simultaneous push and pop leaves the count alone
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Status flags
   assign empty       = (count == '0);
   assign full        = (count == cnt_t'(DEPTH));
   assign almost_full = (count >= cnt_t'(ALMOST_FULL_LEVEL));
   assign prog_full   = (count >= cnt_t'(PROG_FULL_LEVEL));

endmodule

// File: src/cpci_bus_pkg.sv
// CPCI register bridge definitions
package cpci_bus_pkg;

   // --------------------
   // Bus widths
   // --------------------
   localparam int ADDR_W = 27;
   localparam int DATA_W = 32;
   // Request entry is flag + address + write data
   localparam int REQ_W  = 1 + ADDR_W + DATA_W;

   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [DATA_W-1:0] data_t;
   // Packed as {rd_wr_l, addr, wr_data}
   typedef logic [REQ_W-1:0]  req_t;

   // --------------------
   // FIFO sizing
   // --------------------
   localparam int REQ_FIFO_DEPTH        = 16;
   localparam int RSP_FIFO_DEPTH        = 16;
   // Host write-ready drops at this fill level
   localparam int REQ_PROG_FULL_LEVEL   = 12;
   // Read replies are discarded once the response FIFO reaches this level
   localparam int RSP_ALMOST_FULL_LEVEL = 15;

   // --------------------
   // Register map
   // --------------------
   localparam int    NUM_SCRATCH    = 16;
   localparam int    SCRATCH_IDX_W  = $clog2(NUM_SCRATCH);
   localparam addr_t ADDR_ID        = 27'd16;
   localparam addr_t ADDR_WR_COUNT  = 27'd17;
   localparam data_t ID_VALUE       = 32'h4350_4349;
   localparam data_t BAD_ADDR_VALUE = 32'hDEAD_BEEF;

   // Host request state machine
   typedef enum logic [1:0] {
      P2N_IDLE,
      P2N_READING,
      P2N_RD_DONE
   } p2n_state_t;

endpackage
